//--- hdl/rv_pkg.sv
package rv_pkg;

    localparam int xlen = 32;
    localparam int reg_addr_w = 5;
    localparam int reg_count = 1 << reg_addr_w;
    localparam logic [xlen-1:0] reset_pc = 32'h8000_0000;

    // One-hot sequencing states
    typedef enum logic [5:0] {
        INIT      = 6'b000001,
        FETCH     = 6'b000010,
        WAIT_INST = 6'b000100,
        DECODE    = 6'b001000,
        EXECUTE   = 6'b010000,
        WRITEBACK = 6'b100000
    } state_e;

    // Major opcodes, encoded as in the ISA
    typedef enum logic [6:0] {
        OP      = 7'b0110011,
        OP_IMM  = 7'b0010011,
        LUI     = 7'b0110111,
        AUIPC   = 7'b0010111,
        JAL     = 7'b1101111,
        JALR    = 7'b1100111,
        BRANCH  = 7'b1100011,
        ILLEGAL = 7'b0000000
    } opcode_e;

    typedef enum logic [3:0] {
        ADD, SUB, SLT, SLTU, XOR, OR, AND, SLL, SRL, SRA
    } alu_op_e;

    typedef enum logic {SRC_A_REG, SRC_A_PC} src_a_e;
    typedef enum logic {SRC_B_REG, SRC_B_IMM} src_b_e;
    typedef enum logic [1:0] {WB_ALU, WB_IMM, WB_PC4} wb_sel_e;

    typedef struct packed {
        opcode_e                opcode;
        logic [reg_addr_w-1:0]  rd;
        logic [reg_addr_w-1:0]  rs1;
        logic [reg_addr_w-1:0]  rs2;
        logic [2:0]             funct3;
        logic                   funct7_b5;
        logic [xlen-1:0]        imm;
    } decoded_t;

    typedef struct packed {
        src_a_e  src_a;
        src_b_e  src_b;
        alu_op_e alu_op;
        logic    ir_write;
        logic    pc_update;
        logic    reg_write;
    } ctrl_t;

    typedef struct packed {
        logic [xlen-1:0] pc;
        logic            valid;
    } inst_req_t;

    typedef struct packed {
        logic [xlen-1:0] instruction;
        logic            valid;
    } inst_rsp_t;

    typedef struct packed {
        logic                  valid;
        logic                  wen;
        logic [reg_addr_w-1:0] waddr;
        logic [xlen-1:0]       wdata;
        logic [xlen-1:0]       pc;
    } retire_t;

endpackage

//--- hdl/rv_regfile.sv
module rv_regfile import rv_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [reg_addr_w-1:0] raddr1,
    input  logic [reg_addr_w-1:0] raddr2,
    input  logic                  wen,
    input  logic [reg_addr_w-1:0] waddr,
    input  logic [xlen-1:0]       wdata,
    output logic [xlen-1:0]       rdata1,
    output logic [xlen-1:0]       rdata2
);

    logic [xlen-1:0] regs [reg_count];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < reg_count; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    // x0 reads as zero
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

//--- hdl/rv_fetch.sv
module rv_fetch import rv_pkg::*; (
    input  logic            clk,
    input  logic            rst,
    input  ctrl_t           ctrl,
    input  logic [xlen-1:0] instruction,
    input  logic            take_target,
    input  logic [xlen-1:0] target,
    output logic [xlen-1:0] pc,
    output logic [xlen-1:0] pc_plus4,
    output logic [xlen-1:0] ir,
    output logic [xlen-1:0] retire_pc
);

    // Program counter, moves once per instruction at the end of EXECUTE
    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= reset_pc;
        end else if (ctrl.pc_update) begin
            pc <= take_target ? target : pc_plus4;
        end
    end

    // Instruction register and the address it came from
    always_ff @(posedge clk) begin
        if (ctrl.ir_write) begin
            ir        <= instruction;
            retire_pc <= pc;
        end
    end

    // Based on the held address so the link value survives the PC update
    // into WRITEBACK
    assign pc_plus4 = retire_pc + xlen'(4);

endmodule

//--- hdl/rv_decode.sv
module rv_decode import rv_pkg::*; (
    input  logic [xlen-1:0] ir,
    output decoded_t        dec
);

    opcode_e         opcode;
    logic [xlen-1:0] imm_i;
    logic [xlen-1:0] imm_u;
    logic [xlen-1:0] imm_b;
    logic [xlen-1:0] imm_j;

    // Only the kept major opcodes pass through
    always_comb begin
        case (ir[6:0])
            OP, OP_IMM, LUI, AUIPC, JAL, JALR, BRANCH: opcode = opcode_e'(ir[6:0]);
            default: opcode = ILLEGAL;
        endcase
    end

    assign imm_i = {{20{ir[31]}}, ir[31:20]};
    assign imm_u = {ir[31:12], 12'b0};
    assign imm_b = {{20{ir[31]}}, ir[7], ir[30:25], ir[11:8], 1'b0};
    assign imm_j = {{12{ir[31]}}, ir[19:12], ir[20], ir[30:21], 1'b0};

    always_comb begin
        dec.opcode    = opcode;
        dec.rs1       = ir[19:15];
        dec.rs2       = ir[24:20];
        dec.funct3    = ir[14:12];
        dec.funct7_b5 = ir[30];
        // B-type has no destination, bits 11:7 are immediate there
        if (opcode == BRANCH || opcode == ILLEGAL) begin
            dec.rd = '0;
        end else begin
            dec.rd = ir[11:7];
        end
        case (opcode)
            OP_IMM, JALR: dec.imm = imm_i;
            LUI, AUIPC:   dec.imm = imm_u;
            BRANCH:       dec.imm = imm_b;
            JAL:          dec.imm = imm_j;
            default:      dec.imm = '0;
        endcase
    end

endmodule

//--- hdl/rv_control.sv
module rv_control import rv_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  decoded_t dec,
    input  logic     inst_req_ready,
    input  logic     inst_rsp_valid,
    output logic     inst_req_valid,
    output logic     inst_ready,
    output ctrl_t    ctrl,
    output logic     retire_valid
);

    state_e  state;
    state_e  state_next;
    alu_op_e exec_op;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= INIT;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        case (state)
            INIT:      state_next = FETCH;
            FETCH:     state_next = inst_req_ready ? WAIT_INST : FETCH;
            WAIT_INST: state_next = inst_rsp_valid ? DECODE : WAIT_INST;
            DECODE:    state_next = EXECUTE;
            // Branches have nothing to write and finish here
            EXECUTE:   state_next = (dec.opcode == BRANCH) ? FETCH : WRITEBACK;
            WRITEBACK: state_next = FETCH;
            default:   state_next = INIT;
        endcase
    end

    // ALU function from funct3 with funct7 bit 5 picking SUB and SRA
    always_comb begin
        case (dec.funct3)
            3'b000:  exec_op = (dec.opcode == OP && dec.funct7_b5) ? SUB : ADD;
            3'b001:  exec_op = SLL;
            3'b010:  exec_op = SLT;
            3'b011:  exec_op = SLTU;
            3'b100:  exec_op = XOR;
            3'b101:  exec_op = dec.funct7_b5 ? SRA : SRL;
            3'b110:  exec_op = OR;
            default: exec_op = AND;
        endcase
        if (dec.opcode == BRANCH) begin
            // Equality tests look at a zero difference
            case (dec.funct3[2:1])
                2'b10:   exec_op = SLT;
                2'b11:   exec_op = SLTU;
                default: exec_op = SUB;
            endcase
        end else if (dec.opcode != OP && dec.opcode != OP_IMM) begin
            // AUIPC and the jumps only add
            exec_op = ADD;
        end
    end

    always_comb begin
        ctrl.src_a     = SRC_A_REG;
        ctrl.src_b     = SRC_B_REG;
        ctrl.alu_op    = ADD;
        ctrl.ir_write  = (state == WAIT_INST) && inst_rsp_valid;
        ctrl.pc_update = (state == EXECUTE);
        ctrl.reg_write = (state == WRITEBACK) && (dec.opcode != ILLEGAL);
        if (state == EXECUTE) begin
            ctrl.alu_op = exec_op;
            ctrl.src_a  = (dec.opcode == AUIPC) ? SRC_A_PC : SRC_A_REG;
            if (dec.opcode == OP_IMM || dec.opcode == AUIPC) begin
                ctrl.src_b = SRC_B_IMM;
            end
        end
    end

    assign inst_req_valid = (state == FETCH);
    assign inst_ready     = (state == WAIT_INST);
    assign retire_valid   = (state == WRITEBACK) ||
                            ((state == EXECUTE) && (dec.opcode == BRANCH));

endmodule

//--- hdl/rv_execute.sv
module rv_execute import rv_pkg::*; (
    input  logic            clk,
    input  logic            rst,
    input  decoded_t        dec,
    input  ctrl_t           ctrl,
    input  logic [xlen-1:0] rs1_data,
    input  logic [xlen-1:0] rs2_data,
    input  logic [xlen-1:0] pc,
    input  logic [xlen-1:0] pc_plus4,
    output logic            take_target,
    output logic [xlen-1:0] target,
    output logic [xlen-1:0] wb_data
);

    logic [xlen-1:0] op_a;
    logic [xlen-1:0] op_b;
    logic [4:0]      shamt;
    logic [xlen-1:0] alu_res;
    logic [xlen-1:0] result_q;
    logic            branch_taken;
    wb_sel_e         wb_sel;

    assign op_a  = (ctrl.src_a == SRC_A_PC) ? pc : rs1_data;
    assign op_b  = (ctrl.src_b == SRC_B_IMM) ? dec.imm : rs2_data;
    assign shamt = op_b[4:0];

    always_comb begin
        case (ctrl.alu_op)
            ADD:     alu_res = op_a + op_b;
            SUB:     alu_res = op_a - op_b;
            SLT:     alu_res = {{(xlen-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            SLTU:    alu_res = {{(xlen-1){1'b0}}, op_a < op_b};
            XOR:     alu_res = op_a ^ op_b;
            OR:      alu_res = op_a | op_b;
            AND:     alu_res = op_a & op_b;
            SLL:     alu_res = op_a << shamt;
            SRL:     alu_res = op_a >> shamt;
            SRA:     alu_res = $unsigned($signed(op_a) >>> shamt);
            default: alu_res = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            result_q <= '0;
        end else if (ctrl.pc_update) begin
            result_q <= alu_res;
        end
    end

    // funct3 bit 2 picks a less-than test over equality, bit 0 inverts it
    assign branch_taken = dec.funct3[2] ? (alu_res[0] ^ dec.funct3[0])
                                        : ((alu_res == '0) ^ dec.funct3[0]);

    assign take_target = (dec.opcode == JAL) || (dec.opcode == JALR) ||
                         ((dec.opcode == BRANCH) && branch_taken);

    always_comb begin
        if (dec.opcode == JALR) begin
            target = (rs1_data + dec.imm) & ~xlen'(1);
        end else begin
            target = pc + dec.imm;
        end
    end

    always_comb begin
        case (dec.opcode)
            LUI:       wb_sel = WB_IMM;
            JAL, JALR: wb_sel = WB_PC4;
            default:   wb_sel = WB_ALU;
        endcase
    end

    // Zero when nothing is written back, as seen on the retire port
    always_comb begin
        if (!ctrl.reg_write) begin
            wb_data = '0;
        end else begin
            case (wb_sel)
                WB_IMM:  wb_data = dec.imm;
                WB_PC4:  wb_data = pc_plus4;
                default: wb_data = result_q;
            endcase
        end
    end

endmodule

//--- hdl/rv_core.sv
module rv_core import rv_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    output inst_req_t inst_req,
    input  logic      inst_req_ready,
    input  inst_rsp_t inst_rsp,
    output logic      inst_ready,
    output retire_t   retire
);

    ctrl_t           ctrl;
    decoded_t        dec;
    logic [xlen-1:0] pc;
    logic [xlen-1:0] pc_plus4;
    logic [xlen-1:0] ir;
    logic [xlen-1:0] retire_pc;
    logic [xlen-1:0] target;
    logic [xlen-1:0] wb_data;
    logic [xlen-1:0] rs1_data;
    logic [xlen-1:0] rs2_data;
    logic            take_target;
    logic            inst_req_valid;
    logic            retire_valid;

    rv_fetch u_fetch (
        .clk(clk), .rst(rst), .ctrl(ctrl), .instruction(inst_rsp.instruction),
        .take_target(take_target), .target(target),
        .pc(pc), .pc_plus4(pc_plus4), .ir(ir), .retire_pc(retire_pc)
    );

    rv_decode u_decode (.ir(ir), .dec(dec));

    rv_control u_control (
        .clk(clk), .rst(rst), .dec(dec), .inst_req_ready(inst_req_ready),
        .inst_rsp_valid(inst_rsp.valid), .inst_req_valid(inst_req_valid),
        .inst_ready(inst_ready), .ctrl(ctrl), .retire_valid(retire_valid)
    );

    rv_execute u_execute (
        .clk(clk), .rst(rst), .dec(dec), .ctrl(ctrl), .rs1_data(rs1_data),
        .rs2_data(rs2_data), .pc(pc), .pc_plus4(pc_plus4),
        .take_target(take_target), .target(target), .wb_data(wb_data)
    );

    rv_regfile u_regfile (
        .clk(clk), .rst(rst), .raddr1(dec.rs1), .raddr2(dec.rs2),
        .wen(ctrl.reg_write), .waddr(dec.rd), .wdata(wb_data),
        .rdata1(rs1_data), .rdata2(rs2_data)
    );

    assign inst_req = '{pc: pc, valid: inst_req_valid};

    assign retire = '{valid: retire_valid, wen: ctrl.reg_write, waddr: dec.rd,
                      wdata: wb_data, pc: retire_pc};

endmodule

//--- include/tb_program.svh
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

// Each line is one instruction word and the record it retires with
// Last argument leaves a skipped slot behind a taken branch or jump
task automatic load_program();
    emit(enc_i(5, 0, 0, 1, OP_IMM), 1, 1, 32'h0000_0005, 0);
    emit(enc_i(-3, 0, 0, 2, OP_IMM), 1, 2, 32'hffff_fffd, 0);
    emit(enc_r(0, 2, 1, 0, 3), 1, 3, 32'h0000_0002, 0);
    emit(enc_r(7'h20, 2, 1, 0, 4), 1, 4, 32'h0000_0008, 0);
    emit(enc_r(0, 2, 1, 4, 5), 1, 5, 32'hffff_fff8, 0);
    emit(enc_r(0, 2, 1, 6, 6), 1, 6, 32'hffff_fffd, 0);
    emit(enc_r(0, 2, 1, 7, 7), 1, 7, 32'h0000_0005, 0);
    emit(enc_r(0, 1, 2, 2, 8), 1, 8, 32'h0000_0001, 0);
    emit(enc_r(0, 1, 2, 3, 9), 1, 9, 32'h0000_0000, 0);
    emit(enc_i(4, 1, 1, 10, OP_IMM), 1, 10, 32'h0000_0050, 0);
    emit(enc_r(0, 1, 2, 5, 11), 1, 11, 32'h07ff_ffff, 0);
    emit(enc_r(7'h20, 1, 2, 5, 12), 1, 12, 32'hffff_ffff, 0);
    // Write to x0, then read it back
    emit(enc_i(7, 1, 0, 0, OP_IMM), 1, 0, 32'h0000_000c, 0);
    emit(enc_r(0, 1, 0, 0, 13), 1, 13, 32'h0000_0005, 0);
    emit(enc_u(32'h12345, 14, LUI), 1, 14, 32'h1234_5000, 0);
    emit(enc_u(32'h00001, 15, AUIPC), 1, 15, 32'h8000_103c, 0);
    // Branches, x1 = 5 and x2 = -3
    emit(enc_b(8, 1, 1, 0), 0, 0, 0, 1);
    emit(enc_b(8, 2, 1, 0), 0, 0, 0, 0);
    emit(enc_b(8, 2, 1, 1), 0, 0, 0, 1);
    emit(enc_b(8, 1, 1, 1), 0, 0, 0, 0);
    emit(enc_b(8, 1, 2, 4), 0, 0, 0, 1);
    emit(enc_b(8, 2, 1, 4), 0, 0, 0, 0);
    emit(enc_b(8, 2, 1, 5), 0, 0, 0, 1);
    emit(enc_b(8, 1, 2, 5), 0, 0, 0, 0);
    emit(enc_b(8, 2, 1, 6), 0, 0, 0, 1);
    emit(enc_b(8, 1, 2, 6), 0, 0, 0, 0);
    emit(enc_b(8, 1, 2, 7), 0, 0, 0, 1);
    emit(enc_b(8, 2, 1, 7), 0, 0, 0, 0);
    emit(enc_j(8, 16), 1, 16, 32'h8000_008c, 1);
    emit(enc_u(0, 17, AUIPC), 1, 17, 32'h8000_0090, 0);
    // Odd target, bit 0 gets cleared
    emit(enc_i(13, 17, 0, 18, JALR), 1, 18, 32'h8000_0098, 1);
    emit(enc_j(0, 0), 1, 0, 32'h8000_00a0, 0);
endtask

`endif

//--- dv/tb_rv_core.sv
module tb_rv_core import rv_pkg::*; ();

    logic            clk = 1'b0;
    logic            rst = 1'b1;
    inst_req_t       inst_req;
    logic            inst_req_ready = 1'b0;
    inst_rsp_t       inst_rsp = '0;
    logic            inst_ready;
    retire_t         retire;

    logic [31:0]     mem [64];
    logic            exp_wen [64];
    logic [4:0]      exp_waddr [64];
    logic [31:0]     exp_wdata [64];
    logic [31:0]     exp_pc [64];
    int              n_words = 0;
    int              n_exp = 0;
    int              ret_idx = 0;
    int              fetch_count = 0;
    int              mismatch_errors = 0;
    int              other_errors = 0;
    logic            done = 1'b0;
    logic            seen_req = 1'b0;
    logic            req_hold = 1'b0;
    logic [31:0]     held_pc = '0;
    logic            req_taken = 1'b0;
    logic            rsp_taken = 1'b0;
    logic [31:0]     lfsr = 32'ha653_9eea;
    int              req_delay = 0;
    int              rsp_delay = 0;
    logic            rsp_pending = 1'b0;
    logic [31:0]     rsp_word = '0;

    rv_core u_rv_core (
        .clk(clk), .rst(rst), .inst_req(inst_req), .inst_req_ready(inst_req_ready),
        .inst_rsp(inst_rsp), .inst_ready(inst_ready), .retire(retire)
    );

    function automatic logic [31:0] enc_r(int f7, int rs2, int rs1, int f3, int rd);
        return {7'(f7), 5'(rs2), 5'(rs1), 3'(f3), 5'(rd), OP};
    endfunction

    function automatic logic [31:0] enc_i(int imm, int rs1, int f3, int rd, opcode_e opc);
        return {12'(imm), 5'(rs1), 3'(f3), 5'(rd), opc};
    endfunction

    function automatic logic [31:0] enc_u(logic [31:0] imm, int rd, opcode_e opc);
        return {imm[19:0], 5'(rd), opc};
    endfunction

    function automatic logic [31:0] enc_b(int imm, int rs2, int rs1, int f3);
        logic [12:0] b;
        b = 13'(imm);
        return {b[12], b[10:5], 5'(rs2), 5'(rs1), 3'(f3), b[4:1], b[11], BRANCH};
    endfunction

    function automatic logic [31:0] enc_j(int imm, int rd);
        logic [20:0] j;
        j = 21'(imm);
        return {j[20], j[10:1], j[11], j[19:12], 5'(rd), JAL};
    endfunction

    // Place a word at the next address and expect its retire record
    task automatic emit(logic [31:0] word, int wen, int rd, logic [31:0] wdata, int skip);
        mem[n_words]      = word;
        exp_wen[n_exp]    = 1'(wen);
        exp_waddr[n_exp]  = 5'(rd);
        exp_wdata[n_exp]  = wdata;
        exp_pc[n_exp]     = reset_pc + 32'(n_words * 4);
        n_exp++;
        n_words += (skip != 0) ? 2 : 1;
    endtask

    `include "tb_program.svh"

    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic [31:0] next_lfsr(logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw_delay(output int d);
        lfsr = next_lfsr(lfsr);
        d = int'(lfsr[0]);
        lfsr = next_lfsr(lfsr);
        d = d * 2 + int'(lfsr[0]);
    endtask

    task automatic mismatch(string name, logic [31:0] got, logic [31:0] want);
        $display("MISMATCH %s: got %h expected %h (record %0d)", name, got, want, ret_idx);
        mismatch_errors++;
    endtask

    task automatic report_failure(string what);
        $display("ERROR: %s", what);
        other_errors++;
    endtask

    task automatic check_retire();
        assert (retire.pc == exp_pc[ret_idx])
            else mismatch("retire.pc", retire.pc, exp_pc[ret_idx]);
        assert (retire.wen == exp_wen[ret_idx])
            else mismatch("retire.wen", 32'(retire.wen), 32'(exp_wen[ret_idx]));
        assert (retire.waddr == exp_waddr[ret_idx])
            else mismatch("retire.waddr", 32'(retire.waddr), 32'(exp_waddr[ret_idx]));
        assert (retire.wdata == exp_wdata[ret_idx])
            else mismatch("retire.wdata", retire.wdata, exp_wdata[ret_idx]);
        assert (fetch_count == ret_idx + 1)
            else report_failure("retire count does not match fetched instructions");
        ret_idx++;
        if (ret_idx == n_exp) begin
            done = 1'b1;
        end
    endtask

    initial begin
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        if (rst) begin
            assert (!inst_req.valid && !inst_ready && !retire.valid)
                else report_failure("handshake or retire active during reset");
        end else begin
            if (inst_req.valid && !seen_req) begin
                assert (inst_req.pc == reset_pc)
                    else mismatch("inst_req.pc", inst_req.pc, reset_pc);
                seen_req = 1'b1;
            end
            // A stalled request keeps its address
            if (req_hold) begin
                assert (inst_req.valid) else report_failure("request dropped before ready");
                assert (inst_req.pc == held_pc) else mismatch("inst_req.pc", inst_req.pc, held_pc);
            end
            req_hold = inst_req.valid && !inst_req_ready;
            held_pc  = inst_req.pc;
            if (inst_rsp.valid && inst_ready) begin
                fetch_count++;
            end
            if (retire.valid && !done) begin
                check_retire();
            end
        end
        req_taken <= !rst && inst_req.valid && inst_req_ready;
        rsp_taken <= !rst && inst_rsp.valid && inst_ready;
    end

    // Instruction memory with random ready and response delays
    always @(negedge clk) begin
        if (rst) begin
            inst_req_ready = 1'b0;
            inst_rsp       = '0;
            rsp_pending    = 1'b0;
        end else begin
            inst_req_ready = 1'b0;
            if (rsp_taken) begin
                inst_rsp.valid = 1'b0;
            end
            if (req_taken) begin
                rsp_word    = mem[6'((inst_req.pc - reset_pc) >> 2)];
                rsp_pending = 1'b1;
                draw_delay(rsp_delay);
            end
            if (rsp_pending) begin
                if (rsp_delay == 0) begin
                    inst_rsp    = '{instruction: rsp_word, valid: 1'b1};
                    rsp_pending = 1'b0;
                end else begin
                    rsp_delay--;
                end
            end else if (inst_req.valid && !req_taken) begin
                if (req_delay == 0) begin
                    inst_req_ready = 1'b1;
                    draw_delay(req_delay);
                end else begin
                    req_delay--;
                end
            end
        end
    end

    initial begin
        wait (!rst);
        repeat (40 * n_words + 20) @(posedge clk);
        report_failure("timeout waiting for the final retire");
        $display("errors: %0d mismatches, %0d other", mismatch_errors, other_errors);
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin
        for (int i = 0; i < 64; i++) begin
            mem[i] = (reset_pc + 32'(i * 4)) ^ 32'h5a5a_5a00;
        end
        load_program();
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        wait (done);
        repeat (2) @(posedge clk);
        $display("errors: %0d mismatches, %0d other", mismatch_errors, other_errors);
        if (mismatch_errors + other_errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

//--- sim.f
+incdir+include
hdl/rv_pkg.sv
hdl/rv_regfile.sv
hdl/rv_fetch.sv
hdl/rv_decode.sv
hdl/rv_control.sv
hdl/rv_execute.sv
hdl/rv_core.sv
dv/tb_rv_core.sv

//--- Makefile
TOOL     := verilator
FLAGS    := --binary --timing --assert -Wno-fatal
TOP      := tb_rv_core
FILELIST := sim.f
LOG      := sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -o $(TOP)
	./obj_dir/$(TOP) | tee $(LOG)
	grep -q "PASS: all tests" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
